// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_icache
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+.
icache_pkg.sv
icache_ff.sv
icache_way_ram.sv
icache_lru.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// File: icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  icache_pkg::icache_req_t         req_i,
    input  logic                            flush_i,
    input  logic                            cache_enable_i,
    input  icache_pkg::tresp_t              tresp_i,
    output logic                            ready_o,
    input  icache_pkg::icache_tag_entry_t   tag_rd [`ICACHE_N_WAY],
    input  icache_pkg::icache_line_t        line_rd [`ICACHE_N_WAY],
    input  icache_pkg::icache_way_t         lru_victim,
    output icache_pkg::fill_req_t           fill_o,
    input  icache_pkg::fill_resp_t          fill_i,
    output icache_pkg::icache_resp_t        resp_o,
    output logic                            stage_load,
    output logic [`ICACHE_VADDR_SIZE-1:0]   vaddr_d,
    input  logic [`ICACHE_VADDR_SIZE-1:0]   vaddr_q,
    output icache_pkg::icache_idx_t         idx_d,
    input  icache_pkg::icache_idx_t         idx_q,
    output icache_pkg::icache_vpn_t         vpn_d,
    input  icache_pkg::icache_vpn_t         vpn_q,
    output icache_pkg::icache_way_t         way_to_replace_d,
    input  icache_pkg::icache_way_t         way_to_replace_q,
    output logic                            cmp_enable_d,
    input  logic                            cmp_enable_q,
    output logic                            cache_enable_d,
    input  logic                            cache_enable_q,
    output logic                            ireq_kill_d,
    input  logic                            ireq_kill_q,
    output icache_pkg::tresp_t              tresp_d,
    input  icache_pkg::tresp_t              tresp_q,
    output logic [`ICACHE_N_WAY-1:0]        tag_wr_en,
    output logic [`ICACHE_N_WAY-1:0]        data_wr_en,
    output icache_pkg::icache_idx_t         wr_idx,
    output icache_pkg::icache_tag_entry_t   tag_wr_data,
    output icache_pkg::icache_line_t        line_wr_data,
    output logic                            lru_touch,
    output icache_pkg::icache_way_t         lru_way
);

    icache_pkg::icache_state_t      state_q, state_d;
    icache_pkg::icache_idx_t        flush_cnt_q;
    icache_pkg::icache_way_t        hit_way;
    icache_pkg::icache_way_t        wr_way;
    icache_pkg::icache_line_t       fill_line_q;
    icache_pkg::icache_line_t       sel_line;
    icache_pkg::icache_off_t        off;
    logic [icache_pkg::WORD_BITS-1:0] word, resp_word_q;
    logic accept, kill, hit, capture, fill_cap, use_fill_q, resp_valid_q;

    assign ready_o = (state_q == icache_pkg::IDLE) && !flush_i;  // Flush wins over a request
    assign accept  = req_i.valid && ready_o;
    assign kill    = ireq_kill_q || req_i.kill;  // Kill at accept or during compare

    // ####################
    // Tag compare
    // ####################
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            if (tag_rd[w].valid && tag_rd[w].tag == tresp_i.ppn) begin
                hit     = cmp_enable_q && cache_enable_q && tresp_i.valid;
                hit_way = icache_pkg::icache_way_t'(w);
            end
        end
    end

    // In IDLE the request feeds the stage, in COMPARE only the translation and way change
    always_comb begin
        stage_load       = accept || (state_q == icache_pkg::COMPARE);
        vaddr_d          = vaddr_q;
        idx_d            = idx_q;  // Also the array read index
        vpn_d            = vpn_q;
        way_to_replace_d = way_to_replace_q;
        cmp_enable_d     = 1'b0;
        cache_enable_d   = cache_enable_q;
        ireq_kill_d      = ireq_kill_q;
        tresp_d          = tresp_q;
        if (state_q == icache_pkg::IDLE) begin
            vaddr_d        = req_i.vaddr;
            idx_d          = req_i.vaddr[icache_pkg::LINE_OFF_BITS +: icache_pkg::IDX_BITS];
            vpn_d          = req_i.vaddr[`ICACHE_VADDR_SIZE-1:`ICACHE_PAGE_BITS];
            cmp_enable_d   = 1'b1;
            cache_enable_d = cache_enable_i;
            ireq_kill_d    = req_i.kill;
            tresp_d        = '0;
        end else if (state_q == icache_pkg::COMPARE) begin
            tresp_d          = tresp_i;
            way_to_replace_d = hit ? hit_way : lru_victim;
        end
    end

    // ####################
    // Next state
    // ####################
    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (flush_i) begin
                    state_d = icache_pkg::FLUSH;
                end else if (accept) begin
                    state_d = icache_pkg::COMPARE;
                end
            end
            icache_pkg::COMPARE: begin
                if (kill) begin
                    state_d = icache_pkg::IDLE;
                end else if (!cache_enable_q) begin
                    state_d = icache_pkg::BYPASS_REQ;
                end else if (hit) begin
                    state_d = icache_pkg::RESP;
                end else begin
                    state_d = icache_pkg::FILL_REQ;
                end
            end
            icache_pkg::FILL_REQ:   if (fill_i.ack)  state_d = icache_pkg::FILL_REL;
            icache_pkg::FILL_REL:   if (!fill_i.ack) state_d = icache_pkg::RESP;
            icache_pkg::BYPASS_REQ: if (fill_i.ack)  state_d = icache_pkg::BYPASS_REL;
            icache_pkg::BYPASS_REL: if (!fill_i.ack) state_d = icache_pkg::RESP;
            icache_pkg::FLUSH: begin
                if (flush_cnt_q == icache_pkg::icache_idx_t'(`ICACHE_N_SET - 1)) begin
                    state_d = icache_pkg::IDLE;
                end
            end
            default: state_d = icache_pkg::IDLE;  // RESP lasts one cycle
        endcase
    end

    // ####################
    // Memory handshake and array writes
    // ####################
    assign fill_o.req   = (state_q == icache_pkg::FILL_REQ) || (state_q == icache_pkg::BYPASS_REQ);
    assign fill_o.paddr = {tresp_q.ppn,
                           vaddr_q[`ICACHE_PAGE_BITS-1:icache_pkg::LINE_OFF_BITS],
                           {icache_pkg::LINE_OFF_BITS{1'b0}}};
    assign capture  = fill_o.req && fill_i.ack;  // Line arrives at this edge
    assign fill_cap = capture && (state_q == icache_pkg::FILL_REQ);

    assign wr_way       = way_to_replace_q;
    assign wr_idx       = (state_q == icache_pkg::FLUSH) ? flush_cnt_q : idx_q;
    assign tag_wr_data  = (state_q == icache_pkg::FLUSH) ? '0 : '{valid: 1'b1, tag: tresp_q.ppn};
    assign line_wr_data = fill_i.line;

    always_comb begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            data_wr_en[w] = fill_cap && (wr_way == icache_pkg::icache_way_t'(w));
            tag_wr_en[w]  = data_wr_en[w] || (state_q == icache_pkg::FLUSH);
        end
    end

    assign lru_touch = (state_q == icache_pkg::COMPARE && hit && !kill) || fill_cap;
    assign lru_way   = (state_q == icache_pkg::COMPARE) ? hit_way : way_to_replace_q;

    // Fetched line for misses and bypasses, the array for hits
    assign off      = vaddr_q[icache_pkg::LINE_OFF_BITS-1:2];
    assign sel_line = use_fill_q ? fill_line_q : line_rd[way_to_replace_q];
    assign word     = sel_line[off*icache_pkg::WORD_BITS +: icache_pkg::WORD_BITS];

    assign resp_o = '{valid: resp_valid_q,
                      vaddr: {vpn_q, vaddr_q[`ICACHE_PAGE_BITS-1:0]},
                      data:  resp_word_q};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= icache_pkg::IDLE;
            flush_cnt_q  <= '0;
            use_fill_q   <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= (state_q == icache_pkg::RESP);
            if (state_q == icache_pkg::FLUSH) begin
                flush_cnt_q <= flush_cnt_q + 1'b1;  // Wraps to zero after the last set
            end
            if (capture) begin
                use_fill_q <= 1'b1;
            end else if (state_q == icache_pkg::COMPARE) begin
                use_fill_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            fill_line_q <= fill_i.line;
        end
        if (state_q == icache_pkg::RESP) begin
            resp_word_q <= word;
        end
    end

endmodule

// File: icache_ff.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ff (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic [`ICACHE_VADDR_SIZE-1:0] vaddr_d,
    output logic [`ICACHE_VADDR_SIZE-1:0] vaddr_q,
    input  icache_pkg::icache_idx_t       idx_d,
    output icache_pkg::icache_idx_t       idx_q,
    input  icache_pkg::icache_vpn_t       vpn_d,
    output icache_pkg::icache_vpn_t       vpn_q,
    input  icache_pkg::icache_way_t       way_to_replace_d,
    output icache_pkg::icache_way_t       way_to_replace_q,
    input  logic                          cmp_enable_d,
    output logic                          cmp_enable_q,
    input  logic                          cache_enable_d,
    output logic                          cache_enable_q,
    input  logic                          ireq_kill_d,
    output logic                          ireq_kill_q,
    input  icache_pkg::tresp_t            tresp_d,
    output icache_pkg::tresp_t            tresp_q,
    input  logic                          load
);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vaddr_q          <= '0;
            idx_q            <= '0;
            vpn_q            <= '0;
            way_to_replace_q <= '0;
            cmp_enable_q     <= 1'b0;
            cache_enable_q   <= 1'b0;
            ireq_kill_q      <= 1'b0;
            tresp_q          <= '0;
        end else if (load) begin
            vaddr_q          <= vaddr_d;
            idx_q            <= idx_d;
            vpn_q            <= vpn_d;
            way_to_replace_q <= way_to_replace_d;  // Hit way or victim after compare
            cmp_enable_q     <= cmp_enable_d;
            cache_enable_q   <= cache_enable_d;
            ireq_kill_q      <= ireq_kill_d;
            tresp_q          <= tresp_d;
        end
    end

endmodule

// File: icache_lru.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_lru (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  icache_pkg::icache_idx_t set,
    input  logic                    touch,
    input  icache_pkg::icache_way_t touched_way,
    input  logic                    valid0,
    input  logic                    valid1,
    output icache_pkg::icache_way_t victim
);

    logic [`ICACHE_N_SET-1:0] lru_q;  // Names the least recently used way of each set

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[set] <= ~touched_way;  // The other way becomes the oldest
        end
    end

    // Empty ways are filled before anything is evicted
    always_comb begin
        if (!valid0) begin
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[set];
        end
    end

endmodule

// File: icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// ####################
// Address widths
// ####################
`define ICACHE_VADDR_SIZE 32
`define ICACHE_PADDR_SIZE 32
`define ICACHE_PAGE_BITS  12

// ####################
// Cache geometry
// ####################
`define ICACHE_N_WAY      2
`define ICACHE_N_SET      16
`define ICACHE_LINE_BYTES 16

`endif

// File: icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    localparam int unsigned IDX_BITS      = $clog2(`ICACHE_N_SET);
    localparam int unsigned OFF_BITS      = $clog2(`ICACHE_LINE_BYTES / 4);  // Word offset
    localparam int unsigned LINE_OFF_BITS = $clog2(`ICACHE_LINE_BYTES);      // Byte offset
    localparam int unsigned WAY_BITS      = $clog2(`ICACHE_N_WAY);
    localparam int unsigned VPN_BITS      = `ICACHE_VADDR_SIZE - `ICACHE_PAGE_BITS;
    localparam int unsigned TAG_BITS      = `ICACHE_PADDR_SIZE - `ICACHE_PAGE_BITS;
    localparam int unsigned LINE_BITS     = `ICACHE_LINE_BYTES * 8;
    localparam int unsigned WORD_BITS     = 32;

    typedef logic [IDX_BITS-1:0]  icache_idx_t;
    typedef logic [OFF_BITS-1:0]  icache_off_t;
    typedef logic [VPN_BITS-1:0]  icache_vpn_t;
    typedef logic [TAG_BITS-1:0]  icache_tag_t;  // Physical page number
    typedef logic [WAY_BITS-1:0]  icache_way_t;
    typedef logic [LINE_BITS-1:0] icache_line_t;

    typedef struct packed {
        logic        valid;
        icache_tag_t tag;
    } icache_tag_entry_t;

    typedef struct packed {
        logic        valid;
        icache_tag_t ppn;
    } tresp_t;

    typedef struct packed {
        logic                          valid;
        logic [`ICACHE_VADDR_SIZE-1:0] vaddr;
        logic                          kill;
    } icache_req_t;

    typedef struct packed {
        logic                          valid;
        logic [`ICACHE_VADDR_SIZE-1:0] vaddr;
        logic [WORD_BITS-1:0]          data;
    } icache_resp_t;

    typedef struct packed {
        logic                          req;
        logic [`ICACHE_PADDR_SIZE-1:0] paddr;  // Line aligned
    } fill_req_t;

    typedef struct packed {
        logic         ack;
        icache_line_t line;
    } fill_resp_t;

    typedef enum logic [2:0] {
        IDLE, COMPARE, FILL_REQ, FILL_REL, BYPASS_REQ, BYPASS_REL, FLUSH, RESP
    } icache_state_t;

endpackage

// File: icache_top.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  icache_pkg::icache_req_t  req_i,
    output logic                     ready_o,
    input  icache_pkg::tresp_t       tresp_i,
    input  logic                     flush_i,
    input  logic                     cache_enable_i,
    output icache_pkg::icache_resp_t resp_o,
    output icache_pkg::fill_req_t    fill_o,
    input  icache_pkg::fill_resp_t   fill_i
);

    logic [`ICACHE_VADDR_SIZE-1:0] vaddr_d, vaddr_q;
    icache_pkg::icache_idx_t       idx_d, idx_q;
    icache_pkg::icache_vpn_t       vpn_d, vpn_q;
    icache_pkg::icache_way_t       way_to_replace_d, way_to_replace_q;
    icache_pkg::tresp_t            tresp_d, tresp_q;
    logic cmp_enable_d, cmp_enable_q;
    logic cache_enable_d, cache_enable_q;
    logic ireq_kill_d, ireq_kill_q;
    logic stage_load;

    icache_pkg::icache_tag_entry_t tag_rd [`ICACHE_N_WAY];
    icache_pkg::icache_line_t      line_rd [`ICACHE_N_WAY];
    logic [`ICACHE_N_WAY-1:0]      tag_wr_en, data_wr_en;
    icache_pkg::icache_idx_t       wr_idx;
    icache_pkg::icache_tag_entry_t tag_wr_data;
    icache_pkg::icache_line_t      line_wr_data;
    icache_pkg::icache_way_t       lru_victim, lru_way;
    logic                          lru_touch;

    icache_ff u_stage (
        .clk_i, .rstn_i,
        .vaddr_d, .vaddr_q, .idx_d, .idx_q, .vpn_d, .vpn_q,
        .way_to_replace_d, .way_to_replace_q,
        .cmp_enable_d, .cmp_enable_q, .cache_enable_d, .cache_enable_q,
        .ireq_kill_d, .ireq_kill_q, .tresp_d, .tresp_q,
        .load (stage_load)
    );

    // ####################
    // Way arrays
    // ####################
    for (genvar w = 0; w < `ICACHE_N_WAY; w++) begin : g_way
        icache_way_ram #(.entry_t(icache_pkg::icache_tag_entry_t)) u_tag (
            .clk_i,
            .rd_idx  (idx_d),  // Request index in IDLE, held index afterwards
            .rd_data (tag_rd[w]),
            .wr_en   (tag_wr_en[w]),
            .wr_idx  (wr_idx),
            .wr_data (tag_wr_data)
        );

        icache_way_ram #(.entry_t(icache_pkg::icache_line_t)) u_data (
            .clk_i,
            .rd_idx  (idx_d),
            .rd_data (line_rd[w]),
            .wr_en   (data_wr_en[w]),
            .wr_idx  (wr_idx),
            .wr_data (line_wr_data)
        );
    end

    icache_lru u_lru (
        .clk_i, .rstn_i,
        .set         (idx_q),
        .touch       (lru_touch),
        .touched_way (lru_way),
        .valid0      (tag_rd[0].valid),
        .valid1      (tag_rd[1].valid),
        .victim      (lru_victim)
    );

    icache_ctrl u_ctrl (
        .clk_i, .rstn_i,
        .req_i, .flush_i, .cache_enable_i, .tresp_i, .ready_o,
        .tag_rd, .line_rd, .lru_victim,
        .fill_o, .fill_i, .resp_o,
        .stage_load,
        .vaddr_d, .vaddr_q, .idx_d, .idx_q, .vpn_d, .vpn_q,
        .way_to_replace_d, .way_to_replace_q,
        .cmp_enable_d, .cmp_enable_q, .cache_enable_d, .cache_enable_q,
        .ireq_kill_d, .ireq_kill_q, .tresp_d, .tresp_q,
        .tag_wr_en, .data_wr_en, .wr_idx, .tag_wr_data, .line_wr_data,
        .lru_touch, .lru_way
    );

endmodule

// File: icache_way_ram.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_way_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                    clk_i,
    input  icache_pkg::icache_idx_t rd_idx,
    output entry_t                  rd_data,
    input  logic                    wr_en,
    input  icache_pkg::icache_idx_t wr_idx,
    input  entry_t                  wr_data
);

    entry_t mem [`ICACHE_N_SET];

    // Read and write share the edge, a read of the written set returns old data
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx];
    end

endmodule

// File: tb_icache.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module tb_icache;

    localparam int unsigned TIMEOUT   = 200;
    localparam logic [1:0]  OP_FETCH  = 2'd0;
    localparam logic [1:0]  OP_KILL   = 2'd1;
    localparam logic [1:0]  OP_FLUSH  = 2'd2;
    localparam logic [1:0]  OP_ENABLE = 2'd3;  // Bit 0 of vaddr is the new enable level

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] vaddr;
        logic [3:0]  fills;  // Memory requests this step should cause
    } step_t;

    localparam int unsigned N_STEPS = 24;

    // Addresses 1034, 2038 and 303C share set 3
    step_t steps [N_STEPS] = '{
        '{OP_FETCH,  32'h0000_1034, 4'd1},  // Cold miss
        '{OP_FETCH,  32'h0000_1034, 4'd0},
        '{OP_FETCH,  32'h0000_1030, 4'd0},  // Same line, other word
        '{OP_FETCH,  32'h0000_2038, 4'd1},
        '{OP_FETCH,  32'h0000_1034, 4'd0},
        '{OP_FETCH,  32'h0000_303C, 4'd1},  // Evicts 2038
        '{OP_FETCH,  32'h0000_1034, 4'd0},
        '{OP_FETCH,  32'h0000_2038, 4'd1},
        '{OP_FETCH,  32'h0000_4050, 4'd1},
        '{OP_FLUSH,  32'h0000_0000, 4'd0},
        '{OP_FETCH,  32'h0000_2038, 4'd1},  // Every line cached before the flush misses
        '{OP_FETCH,  32'h0000_303C, 4'd1},
        '{OP_FETCH,  32'h0000_1034, 4'd1},  // Evicts 2038 again
        '{OP_FETCH,  32'h0000_4050, 4'd1},
        '{OP_KILL,   32'h0000_5064, 4'd0},
        '{OP_FETCH,  32'h0000_5064, 4'd1},  // The kill left nothing behind
        '{OP_ENABLE, 32'h0000_0000, 4'd0},
        '{OP_FETCH,  32'h0000_6070, 4'd1},
        '{OP_FETCH,  32'h0000_6070, 4'd1},
        '{OP_FETCH,  32'h0000_1034, 4'd1},
        '{OP_ENABLE, 32'h0000_0001, 4'd0},
        '{OP_FETCH,  32'h0000_1034, 4'd0},
        '{OP_FETCH,  32'h0000_6070, 4'd1},
        '{OP_FETCH,  32'h0000_6070, 4'd0}
    };

    logic                     clk_i;
    logic                     rstn_i;
    icache_pkg::icache_req_t  req_i;
    logic                     ready_o;
    icache_pkg::tresp_t       tresp_i;
    logic                     flush_i;
    logic                     cache_enable_i;
    icache_pkg::icache_resp_t resp_o;
    icache_pkg::fill_req_t    fill_o;
    icache_pkg::fill_resp_t   fill_i;

    logic [31:0]             cur_vaddr;
    int                      errors;
    int                      timeouts;
    int                      fill_count;
    logic                    ref_valid [`ICACHE_N_SET][2];
    icache_pkg::icache_tag_t ref_tag [`ICACHE_N_SET][2];
    logic                    ref_lru [`ICACHE_N_SET];  // Least recently used way

    // The MMU maps every page to its number XOR 0x100
    assign tresp_i = '{valid: 1'b1, ppn: cur_vaddr[31:12] ^ 20'h00100};

    icache_top DUT (
        .clk_i, .rstn_i, .req_i, .ready_o, .tresp_i, .flush_i,
        .cache_enable_i, .resp_o, .fill_o, .fill_i
    );

    // ####################
    // Helpers
    // ####################
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    function automatic logic [31:0] line_paddr(input logic [31:0] vaddr);
        return {vaddr[31:12] ^ 20'h00100, vaddr[11:4], 4'h0};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] vaddr);
        return (line_paddr(vaddr) + {28'h0, vaddr[3:2], 2'b00}) ^ 32'hC0DE0000;
    endfunction

    // Returns 1 when the access needs a memory request
    function automatic logic ref_fetch(input logic [31:0] vaddr, input logic enable);
        icache_pkg::icache_idx_t idx;
        icache_pkg::icache_tag_t ppn;
        logic                    hit;
        logic                    victim;
        idx = vaddr[7:4];
        ppn = vaddr[31:12] ^ 20'h00100;
        hit = 1'b0;
        if (!enable) begin
            return 1'b1;  // Bypass never allocates
        end
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == ppn) begin
                hit          = 1'b1;
                ref_lru[idx] = (w == 0);
            end
        end
        if (hit) begin
            return 1'b0;
        end
        victim = !ref_valid[idx][0] ? 1'b0 : (!ref_valid[idx][1] ? 1'b1 : ref_lru[idx]);
        ref_valid[idx][victim] = 1'b1;
        ref_tag[idx][victim]   = ppn;
        ref_lru[idx]           = !victim;
        return 1'b1;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready_o && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!ready_o) begin
            $display("Timeout at %0t ns: the cache never became ready", $time);
            timeouts++;
        end
    endtask

    task automatic issue_fetch(input logic [31:0] vaddr, input logic kill, input int exp_fills);
        int edges;
        int fills_at_start;
        wait_ready();
        fills_at_start = fill_count;
        cur_vaddr      = vaddr;
        req_i          = '{valid: 1'b1, vaddr: vaddr, kill: 1'b0};
        tick();  // Accepting edge
        req_i = '{valid: 1'b0, vaddr: vaddr, kill: kill};
        if (kill) begin
            tick();
            req_i.kill = 1'b0;
            check_value(32'(ready_o), 32'd1, "ready after kill");
            repeat (4) begin
                tick();
                check_value(32'(resp_o.valid), 32'd0, "response to killed fetch");
            end
        end else begin
            edges = 0;
            do begin
                tick();
                edges++;
            end while (!resp_o.valid && edges < TIMEOUT);
            if (!resp_o.valid) begin
                $display("Timeout at %0t ns: no response for address %h", $time, vaddr);
                timeouts++;
            end else begin
                check_value(resp_o.data, expected_word(vaddr), "fetched word");
                check_value(resp_o.vaddr, vaddr, "response address");
                if (exp_fills == 0) begin
                    check_value(32'(edges), 32'd2, "hit latency");
                end
                tick();
                check_value(32'(resp_o.valid), 32'd0, "response valid after one cycle");
            end
        end
        check_value(32'(fill_count - fills_at_start), 32'(exp_fills), "memory requests");
    endtask

    task automatic flush_cache();
        int n;
        wait_ready();
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        n       = 0;
        while (!ready_o && n < TIMEOUT) begin
            tick();
            n++;
        end
        check_value(32'(n), 32'd16, "flush busy cycles");
        for (int s = 0; s < `ICACHE_N_SET; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
        end
    endtask

    // ####################
    // Clock and memory
    // ####################
    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Acks each request 1 to 4 cycles after it is seen
    initial begin : memory_model
        icache_pkg::icache_line_t line;
        logic [7:0]               lfsr;
        logic [1:0]               pick;
        int                       n;
        lfsr   = 8'd74;
        fill_i = '0;
        forever begin
            tick();
            if (fill_o.req && !fill_i.ack) begin
                fill_count++;
                check_value(fill_o.paddr, line_paddr(cur_vaddr), "fill address");
                lfsr    = lfsr_next(lfsr);
                pick[0] = lfsr[0];
                lfsr    = lfsr_next(lfsr);
                pick[1] = lfsr[0];
                repeat (pick) tick();
                for (int k = 0; k < 4; k++) begin
                    line[k*32 +: 32] = (fill_o.paddr + 32'(4 * k)) ^ 32'hC0DE0000;
                end
                fill_i = '{ack: 1'b1, line: line};
                n      = 0;
                do begin
                    tick();
                    n++;
                end while (fill_o.req && n < TIMEOUT);
                if (fill_o.req) begin
                    $display("Timeout at %0t ns: the cache kept req high after ack", $time);
                    timeouts++;
                end
                fill_i.ack = 1'b0;
            end
        end
    end

    // ####################
    // Test sequence
    // ####################
    initial begin : stimulus
        int exp_fills;
        errors         = 0;
        timeouts       = 0;
        fill_count     = 0;
        rstn_i         = 1'b0;
        req_i          = '0;
        flush_i        = 1'b0;
        cache_enable_i = 1'b1;
        cur_vaddr      = '0;
        for (int s = 0; s < `ICACHE_N_SET; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
        repeat (8) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        check_value(32'(ready_o), 32'd1, "ready after reset");
        check_value(32'(resp_o.valid), 32'd0, "response valid after reset");
        check_value(32'(fill_o.req), 32'd0, "fill req after reset");

        for (int i = 0; i < N_STEPS && timeouts == 0; i++) begin
            case (steps[i].op)
                OP_FETCH, OP_KILL: begin
                    exp_fills = (steps[i].op == OP_KILL) ? 0 :
                                int'(ref_fetch(steps[i].vaddr, cache_enable_i));
                    check_value(32'(exp_fills), 32'(steps[i].fills), "table fill count");
                    issue_fetch(steps[i].vaddr, steps[i].op == OP_KILL, exp_fills);
                end
                OP_FLUSH: flush_cache();
                default: begin
                    wait_ready();
                    cache_enable_i = steps[i].vaddr[0];
                end
            endcase
        end

        $display("Errors: %0d, timeouts: %0d, memory requests: %0d",
                 errors, timeouts, fill_count);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
